//--- include/core_cfg.svh
// --------------------
// Core configuration
// Widths and stack depths of the accumulator core
// --------------------

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data path width
`define CORE_DATA_W 32

// Instruction word fields
`define CORE_OPCODE_W 7
`define CORE_OPERAND_W 9

// Address widths
`define CORE_IADDR_W 9
`define CORE_DADDR_W 9
`define CORE_IO_ADDR_W 2

// Entries in the return and data stacks
`define CORE_RSTACK_DEPTH 8
`define CORE_DSTACK_DEPTH 8

`endif

//--- hdl/isa_pkg.sv
// --------------------
// Instruction set
// Opcodes and instruction word layout
// --------------------

`include "core_cfg.svh"

package isa_pkg;

	// Unlisted codes decode as NOP
	typedef enum logic [`CORE_OPCODE_W-1:0] {
		NOP   = 0,
		LOD   = 1,
		SET   = 2,
		PSH   = 3,
		ADD   = 4,
		S_ADD = 5,
		AND   = 6,
		S_AND = 7,
		XOR   = 8,
		S_XOR = 9,
		INN   = 10,
		OUT   = 11,
		// Flow control, handled in fetch
		JMP   = 13,
		JIZ   = 14,
		CAL   = 15,
		RET   = 16
	} opcode_t;

	typedef logic [`CORE_OPERAND_W-1:0] operand_t;

	// Opcode in the upper bits
	typedef struct packed {
		opcode_t  opcode;
		operand_t operand;
	} instr_t;

endpackage

//--- hdl/datapath_pkg.sv
// --------------------
// Datapath types
// Data, address and control types plus port bundles
// --------------------

`include "core_cfg.svh"

package datapath_pkg;

	typedef logic [`CORE_DATA_W-1:0]    data_t;
	typedef logic [`CORE_IADDR_W-1:0]   iaddr_t;
	typedef logic [`CORE_DADDR_W-1:0]   daddr_t;
	typedef logic [`CORE_IO_ADDR_W-1:0] ioaddr_t;

	// ALU function; pass ops select one operand unchanged
	typedef enum logic [2:0] {
		PASS_ACC,
		PASS_IN,
		ADD,
		AND,
		XOR
	} alu_op_t;

	// Execute stage controls, registered by the decoder
	typedef struct packed {
		alu_op_t alu_op;
		logic    use_stack;
		logic    use_io;
		logic    acc_we;
		logic    dpush;
		logic    dpop;
		logic    mem_wr;
		logic    out_en;
		logic    req_in;
		daddr_t  daddr;
		ioaddr_t ioaddr;
	} ex_ctrl_t;

	// --------------------
	// External port bundles
	typedef struct packed {
		logic   wr;
		daddr_t addr_rd;
		daddr_t addr_wr;
		data_t  data_wr;
	} dmem_req_t;

	typedef struct packed {
		logic    req_in;
		ioaddr_t addr_in;
		logic    out_en;
		ioaddr_t addr_out;
	} io_req_t;

endpackage

//--- hdl/lifo_stack.sv
// --------------------
// LIFO stack
// Pointer plus register array, top of stack always visible
// --------------------

`timescale 1ns/1ps

module lifo_stack #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] top
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] ptr_inc;
	logic [PTR_W-1:0] ptr_dec;

	// Wrap at DEPTH so non power of two sizes behave
	assign ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	assign ptr_dec = (ptr == '0) ? PTR_W'(DEPTH - 1) : ptr - 1'b1;

	// Push wins over pop
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ptr <= '0;
		else if (push)
			ptr <= ptr_inc;
		else if (pop)
			ptr <= ptr_dec;
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[ptr] <= din;
	end

	// Most recent entry sits just below the pointer
	assign top = mem[ptr_dec];

endmodule

//--- hdl/fetch_unit.sv
// --------------------
// Fetch unit
// Program counter, jump selection and return stack
// --------------------

`timescale 1ns/1ps

`include "core_cfg.svh"

module fetch_unit (
	input  logic                 clk,
	input  logic                 rst,
	input  isa_pkg::instr_t      instr,
	input  logic                 result_zero,
	output datapath_pkg::iaddr_t instr_addr,
	output isa_pkg::instr_t      dec_instr
);

	datapath_pkg::iaddr_t pc;
	datapath_pkg::iaddr_t rs_top;
	logic                 fetch_valid;
	logic                 is_jmp;
	logic                 is_jiz;
	logic                 is_cal;
	logic                 is_ret;
	logic                 take_jump;

	// Word on instr is stale until the first read after reset
	always_comb begin
		dec_instr = instr;
		if (!fetch_valid)
			dec_instr.opcode = isa_pkg::NOP;
	end

	assign is_jmp = (dec_instr.opcode == isa_pkg::JMP);
	assign is_jiz = (dec_instr.opcode == isa_pkg::JIZ);
	assign is_cal = (dec_instr.opcode == isa_pkg::CAL);
	assign is_ret = (dec_instr.opcode == isa_pkg::RET);

	// JIZ looks at the instruction currently in execute
	assign take_jump = is_jmp | is_cal | (is_jiz & result_zero);

	// --------------------
	// Next address, no bubble on a taken jump
	always_comb begin
		if (is_ret)
			instr_addr = rs_top;
		else if (take_jump)
			instr_addr = datapath_pkg::iaddr_t'(dec_instr.operand);
		else
			instr_addr = pc;
	end

	// PC always runs one ahead of the issued address
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc          <= '0;
			fetch_valid <= 1'b0;
		end else begin
			pc          <= instr_addr + 1'b1;
			fetch_valid <= 1'b1;
		end
	end

	// --------------------
	// Return addresses; pc already holds the address after the CAL
	lifo_stack #(
		.WIDTH ($bits(datapath_pkg::iaddr_t)),
		.DEPTH (`CORE_RSTACK_DEPTH)
	) rstack (
		.clk  (clk),
		.rst  (rst),
		.push (is_cal),
		.pop  (is_ret),
		.din  (pc),
		.top  (rs_top)
	);

endmodule

//--- hdl/instr_dec.sv
// --------------------
// Instruction decoder
// Opcode to execute controls, one register stage
// --------------------

`timescale 1ns/1ps

`include "core_cfg.svh"

module instr_dec (
	input  logic                   clk,
	input  logic                   rst,
	input  isa_pkg::instr_t        dec_instr,
	output datapath_pkg::ex_ctrl_t ex_ctrl,
	output datapath_pkg::daddr_t   rd_addr
);

	datapath_pkg::ex_ctrl_t ctrl_d;

	// Synchronous memory read is issued here so data lines up with execute
	assign rd_addr = datapath_pkg::daddr_t'(dec_instr.operand);

	always_comb begin
		ctrl_d        = '0;
		ctrl_d.alu_op = datapath_pkg::PASS_ACC;
		ctrl_d.daddr  = datapath_pkg::daddr_t'(dec_instr.operand);
		ctrl_d.ioaddr = dec_instr.operand[`CORE_IO_ADDR_W-1:0];

		case (dec_instr.opcode)
			isa_pkg::LOD: begin
				ctrl_d.alu_op = datapath_pkg::PASS_IN;
				ctrl_d.acc_we = 1'b1;
			end
			isa_pkg::SET: ctrl_d.mem_wr = 1'b1;
			isa_pkg::PSH: ctrl_d.dpush  = 1'b1;
			isa_pkg::ADD, isa_pkg::S_ADD: begin
				ctrl_d.alu_op = datapath_pkg::ADD;
				ctrl_d.acc_we = 1'b1;
			end
			isa_pkg::AND, isa_pkg::S_AND: begin
				ctrl_d.alu_op = datapath_pkg::AND;
				ctrl_d.acc_we = 1'b1;
			end
			isa_pkg::XOR, isa_pkg::S_XOR: begin
				ctrl_d.alu_op = datapath_pkg::XOR;
				ctrl_d.acc_we = 1'b1;
			end
			// io_in replaces acc as second operand
			isa_pkg::INN: begin
				ctrl_d.use_io = 1'b1;
				ctrl_d.acc_we = 1'b1;
				ctrl_d.req_in = 1'b1;
			end
			isa_pkg::OUT: ctrl_d.out_en = 1'b1;
			// Jumps live in fetch; anything else is a NOP
			default: ;
		endcase

		// Stack forms take the first operand from the data stack
		if (dec_instr.opcode == isa_pkg::S_ADD || dec_instr.opcode == isa_pkg::S_AND ||
		    dec_instr.opcode == isa_pkg::S_XOR) begin
			ctrl_d.use_stack = 1'b1;
			ctrl_d.dpop      = 1'b1;
		end
	end

	// --------------------
	// Decode to execute register
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ex_ctrl <= '0;
		else
			ex_ctrl <= ctrl_d;
	end

endmodule

//--- hdl/exec_unit.sv
// --------------------
// Execute unit
// Operand muxes, ALU, accumulator and data stack
// --------------------

`timescale 1ns/1ps

`include "core_cfg.svh"

module exec_unit (
	input  logic                    clk,
	input  logic                    rst,
	input  datapath_pkg::ex_ctrl_t  ex_ctrl,
	input  datapath_pkg::data_t     mem_data_rd,
	input  datapath_pkg::data_t     io_in,
	output datapath_pkg::dmem_req_t dmem,
	output datapath_pkg::io_req_t   io,
	output logic                    result_zero
);

	datapath_pkg::data_t acc;
	datapath_pkg::data_t dtop;
	datapath_pkg::data_t in1;
	datapath_pkg::data_t in2;
	datapath_pkg::data_t alu_res;
	datapath_pkg::data_t acc_next;

	// --------------------
	// Operand select
	assign in1 = ex_ctrl.use_stack ? dtop : mem_data_rd;
	assign in2 = ex_ctrl.use_io ? io_in : acc;

	always_comb begin
		case (ex_ctrl.alu_op)
			datapath_pkg::PASS_IN: alu_res = in1;
			datapath_pkg::ADD:     alu_res = in1 + in2;
			datapath_pkg::AND:     alu_res = in1 & in2;
			datapath_pkg::XOR:     alu_res = in1 ^ in2;
			default:               alu_res = in2;
		endcase
	end

	// Value acc will hold after this cycle, used by JIZ in fetch
	assign acc_next    = ex_ctrl.acc_we ? alu_res : acc;
	assign result_zero = (acc_next == '0);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			acc <= '0;
		else if (ex_ctrl.acc_we)
			acc <= alu_res;
	end

	// --------------------
	// Data stack, PSH pushes acc and the S_ ops pop
	lifo_stack #(
		.WIDTH ($bits(datapath_pkg::data_t)),
		.DEPTH (`CORE_DSTACK_DEPTH)
	) dstack (
		.clk  (clk),
		.rst  (rst),
		.push (ex_ctrl.dpush),
		.pop  (ex_ctrl.dpop),
		.din  (acc),
		.top  (dtop)
	);

	// Memory write side; read address is merged in at the top level
	assign dmem.wr      = ex_ctrl.mem_wr;
	assign dmem.addr_rd = '0;
	assign dmem.addr_wr = ex_ctrl.daddr;
	// Shared by SET and OUT
	assign dmem.data_wr = acc;

	// I/O strobes for the execute cycle
	assign io.req_in   = ex_ctrl.req_in;
	assign io.addr_in  = ex_ctrl.ioaddr;
	assign io.out_en   = ex_ctrl.out_en;
	assign io.addr_out = ex_ctrl.ioaddr;

endmodule

//--- hdl/proc_core.sv
// --------------------
// Processor core
// Fetch, decode and execute of the accumulator machine
// --------------------

`timescale 1ns/1ps

module proc_core (
	input  logic                    clk,
	input  logic                    rst,
	input  isa_pkg::instr_t         instr,
	output datapath_pkg::iaddr_t    instr_addr,
	input  datapath_pkg::data_t     mem_data_rd,
	output datapath_pkg::dmem_req_t dmem,
	input  datapath_pkg::data_t     io_in,
	output datapath_pkg::io_req_t   io
);

	isa_pkg::instr_t         dec_instr;
	datapath_pkg::ex_ctrl_t  ex_ctrl;
	datapath_pkg::daddr_t    rd_addr;
	datapath_pkg::dmem_req_t ex_dmem;
	logic                    result_zero;

	fetch_unit u_fetch (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.result_zero (result_zero),
		.instr_addr  (instr_addr),
		.dec_instr   (dec_instr)
	);

	instr_dec u_dec (
		.clk       (clk),
		.rst       (rst),
		.dec_instr (dec_instr),
		.ex_ctrl   (ex_ctrl),
		.rd_addr   (rd_addr)
	);

	exec_unit u_exec (
		.clk         (clk),
		.rst         (rst),
		.ex_ctrl     (ex_ctrl),
		.mem_data_rd (mem_data_rd),
		.io_in       (io_in),
		.dmem        (ex_dmem),
		.io          (io),
		.result_zero (result_zero)
	);

	// Read address comes from decode, one stage ahead of the write side
	always_comb begin
		dmem         = ex_dmem;
		dmem.addr_rd = rd_addr;
	end

endmodule

//--- tb/proc_core_props.sv
// --------------------
// Core strobe checks
// Bound to proc_core, watches memory and I/O strobes
// --------------------

`timescale 1ns/1ps

module proc_core_props (
	input logic                    clk,
	input logic                    rst,
	input datapath_pkg::dmem_req_t dmem,
	input datapath_pkg::io_req_t   io
);

	logic quiet;

	assign quiet = !dmem.wr && !io.out_en && !io.req_in;

	// No valid word reaches execute until two cycles after reset
	quiet_after_reset: assert property (@(posedge clk)
		(rst || $past(rst) || $past(rst, 2)) |-> quiet)
		else $error("Memory or I/O strobe active before the first valid instruction");

	// SET and OUT share data_wr, only one of them per cycle
	wr_out_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(dmem.wr && io.out_en))
		else $error("dmem.wr and io.out_en high in the same cycle");

	req_in_single: assert property (@(posedge clk) disable iff (rst)
		io.req_in |=> !io.req_in)
		else $error("io.req_in held for more than one cycle");

endmodule

bind proc_core proc_core_props props_chk (
	.clk  (clk),
	.rst  (rst),
	.dmem (dmem),
	.io   (io)
);

//--- tb/proc_core_tb.sv
// --------------------
// Accumulator core testbench
// Runs a table of stack ALU cases through one fixed program
// with ROM, RAM and I/O port models around the core
// --------------------

`timescale 1ns/1ps

`include "core_cfg.svh"

module proc_core_tb;

	localparam int N_ROWS     = 8;
	localparam int ROW_LIMIT  = 40;
	localparam int RST_CYCLES = 2;
	localparam int MAX_CYCLES = N_ROWS * ROW_LIMIT;
	localparam int RAM_DEPTH  = 1 << `CORE_DADDR_W;
	// Data addresses used by the program
	localparam int C_ADDR     = 20;
	localparam int RES_ADDR   = 30;

	typedef struct packed {
		isa_pkg::opcode_t    op;
		datapath_pkg::data_t a;
		datapath_pkg::data_t b;
		datapath_pkg::data_t c;
		datapath_pkg::data_t r1;
		datapath_pkg::data_t r2;
	} row_t;

	logic                    clk = 1'b0;
	logic                    rst;
	isa_pkg::instr_t         instr = '0;
	datapath_pkg::iaddr_t    instr_addr;
	datapath_pkg::data_t     mem_data_rd = '0;
	datapath_pkg::dmem_req_t dmem;
	datapath_pkg::data_t     io_in;
	datapath_pkg::io_req_t   io;

	isa_pkg::opcode_t     cur_op;
	datapath_pkg::data_t  a_cur;
	datapath_pkg::data_t  b_cur;
	logic                 load_en;
	datapath_pkg::daddr_t load_addr;
	datapath_pkg::data_t  load_data;
	datapath_pkg::data_t  ram [RAM_DEPTH];
	row_t                 table_rows [N_ROWS];
	int                   seed = 32'hd628_ffac;
	int                   cycle_cnt = 0;
	int                   check_count = 0;
	int                   error_count = 0;

	always #2 clk = ~clk;

	function automatic isa_pkg::instr_t encode_instr(input isa_pkg::opcode_t op, input int arg);
		isa_pkg::instr_t w;
		w.opcode  = op;
		w.operand = isa_pkg::operand_t'(arg);
		return w;
	endfunction

	// Test program with the row op at word 3; unused words jump to themselves
	function automatic isa_pkg::instr_t program_word(input datapath_pkg::iaddr_t addr,
			input isa_pkg::opcode_t op);
		case (int'(addr))
			0:       return encode_instr(isa_pkg::INN, 0);
			1:       return encode_instr(isa_pkg::PSH, 0);
			2:       return encode_instr(isa_pkg::INN, 1);
			3:       return encode_instr(op, 0);
			4:       return encode_instr(isa_pkg::OUT, 0);
			5:       return encode_instr(isa_pkg::ADD, C_ADDR);
			6:       return encode_instr(isa_pkg::OUT, 1);
			7:       return encode_instr(isa_pkg::JIZ, 9);
			8:       return encode_instr(isa_pkg::OUT, 2);
			9:       return encode_instr(isa_pkg::CAL, 12);
			10:      return encode_instr(isa_pkg::OUT, 3);
			11:      return encode_instr(isa_pkg::JMP, 11);
			12:      return encode_instr(isa_pkg::SET, RES_ADDR);
			13:      return encode_instr(isa_pkg::RET, 0);
			default: return encode_instr(isa_pkg::JMP, int'(addr));
		endcase
	endfunction

	function automatic datapath_pkg::data_t stack_op_result(input isa_pkg::opcode_t op,
			input datapath_pkg::data_t a, input datapath_pkg::data_t b);
		case (op)
			isa_pkg::S_ADD: return a + b;
			isa_pkg::S_AND: return a & b;
			isa_pkg::S_XOR: return a ^ b;
			default:        return '0;
		endcase
	endfunction

	// --------------------
	// Memory and port models
	always @(posedge clk)
		instr <= program_word(instr_addr, cur_op);

	always @(posedge clk) begin
		if (dmem.wr)
			ram[dmem.addr_wr] <= dmem.data_wr;
		else if (load_en)
			ram[load_addr] <= load_data;
		mem_data_rd <= ram[dmem.addr_rd];
	end

	assign io_in = (io.addr_in == 2'd0) ? a_cur : ((io.addr_in == 2'd1) ? b_cur : '0);

	proc_core UUT (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_addr  (instr_addr),
		.mem_data_rd (mem_data_rd),
		.dmem        (dmem),
		.io_in       (io_in),
		.io          (io)
	);

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Run stopped after %0d cycles without finishing the table", cycle_cnt);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// --------------------
	// Table and checks
	task automatic add_row(input int idx, input isa_pkg::opcode_t op,
			input datapath_pkg::data_t a, input datapath_pkg::data_t b,
			input datapath_pkg::data_t c);
		table_rows[idx].op = op;
		table_rows[idx].a  = a;
		table_rows[idx].b  = b;
		table_rows[idx].c  = c;
		table_rows[idx].r1 = stack_op_result(op, a, b);
		table_rows[idx].r2 = table_rows[idx].r1 + c;
	endtask

	// Rows 1, 3 and 5 cancel to zero so JIZ is taken there
	task automatic build_table();
		datapath_pkg::data_t a;
		datapath_pkg::data_t b;
		datapath_pkg::data_t c;
		add_row(0, isa_pkg::S_ADD, 32'd5, 32'd7, 32'd100);
		a = 32'hf0f0_1234;
		b = 32'h0ff0_ffff;
		add_row(1, isa_pkg::S_AND, a, b, '0 - stack_op_result(isa_pkg::S_AND, a, b));
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		add_row(2, isa_pkg::S_XOR, a, b, c);
		a = $random(seed);
		b = $random(seed);
		add_row(3, isa_pkg::S_ADD, a, b, '0 - stack_op_result(isa_pkg::S_ADD, a, b));
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		add_row(4, isa_pkg::S_AND, a, b, c);
		add_row(5, isa_pkg::S_XOR, 32'hdead_beef, 32'hdead_beef, '0);
		add_row(6, isa_pkg::S_ADD, 32'hffff_ffff, 32'd1, 32'h0000_1234);
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		add_row(7, isa_pkg::S_XOR, a, b, c);
	endtask

	task automatic flag_error(input string msg);
		error_count++;
		$display("Fail at time %0t: %s", $time, msg);
	endtask

	task automatic check_row(input int r, input row_t row, input logic seen,
			input datapath_pkg::ioaddr_t got_addr[$], input datapath_pkg::data_t got_data[$],
			input int wr_count, input datapath_pkg::daddr_t wr_addr, input int req_count);
		datapath_pkg::ioaddr_t exp_addr[$];
		datapath_pkg::data_t   exp_data[$];
		int                    n;
		// Port 2 only when JIZ falls through
		for (int p = 0; p < 4; p++) begin
			if (p != 2 || row.r2 != '0) begin
				exp_addr.push_back(datapath_pkg::ioaddr_t'(p));
				exp_data.push_back((p == 0) ? row.r1 : row.r2);
			end
		end
		check_count++;
		if (!seen) begin
			error_count++;
			$display("Row %0d never reached the OUT to port 3 within %0d cycles", r, ROW_LIMIT);
		end
		check_count++;
		if (got_addr.size() != exp_addr.size())
			flag_error($sformatf("row %0d: %0d OUT events, expected %0d", r,
				got_addr.size(), exp_addr.size()));
		n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
		for (int k = 0; k < n; k++) begin
			check_count++;
			if (got_addr[k] != exp_addr[k] || got_data[k] != exp_data[k])
				flag_error($sformatf("row %0d event %0d: port %0d data %h, expected port %0d data %h",
					r, k, got_addr[k], got_data[k], exp_addr[k], exp_data[k]));
		end
		// One input request per INN in the program
		check_count++;
		if (req_count != 2)
			flag_error($sformatf("row %0d: %0d input requests, expected 2", r, req_count));
		check_count++;
		if (wr_count != 1 || wr_addr != datapath_pkg::daddr_t'(RES_ADDR))
			flag_error($sformatf("row %0d: %0d memory writes, last to %0d", r, wr_count, wr_addr));
		check_count++;
		if (ram[RES_ADDR] != row.r2)
			flag_error($sformatf("row %0d: mem[%0d] = %h, expected %h", r, RES_ADDR,
				ram[RES_ADDR], row.r2));
	endtask

	task automatic run_row(input int r);
		row_t                  row;
		datapath_pkg::ioaddr_t got_addr[$];
		datapath_pkg::data_t   got_data[$];
		logic                  seen;
		int                    wr_count;
		int                    req_count;
		datapath_pkg::daddr_t  wr_addr;
		row       = table_rows[r];
		seen      = 1'b0;
		wr_count  = 0;
		req_count = 0;
		wr_addr   = '0;
		// c and a stale result word go into the RAM during reset
		@(posedge clk);
		rst       <= 1'b1;
		cur_op    <= row.op;
		a_cur     <= row.a;
		b_cur     <= row.b;
		load_en   <= 1'b1;
		load_addr <= datapath_pkg::daddr_t'(C_ADDR);
		load_data <= row.c;
		@(posedge clk);
		load_addr <= datapath_pkg::daddr_t'(RES_ADDR);
		load_data <= ~row.r2;
		@(posedge clk);
		rst     <= 1'b0;
		load_en <= 1'b0;
		// Strobes sampled mid-cycle
		for (int cyc = 0; cyc < ROW_LIMIT - RST_CYCLES - 1 && !seen; cyc++) begin
			@(negedge clk);
			if (io.out_en) begin
				got_addr.push_back(io.addr_out);
				got_data.push_back(dmem.data_wr);
				if (io.addr_out == 2'd3)
					seen = 1'b1;
			end
			if (io.req_in)
				req_count++;
			if (dmem.wr) begin
				wr_count++;
				wr_addr = dmem.addr_wr;
			end
		end
		check_row(r, row, seen, got_addr, got_data, wr_count, wr_addr, req_count);
	endtask

	initial begin
		rst       <= 1'b1;
		cur_op    <= isa_pkg::NOP;
		a_cur     <= '0;
		b_cur     <= '0;
		load_en   <= 1'b0;
		load_addr <= '0;
		load_data <= '0;
		build_table();
		for (int r = 0; r < N_ROWS; r++)
			run_row(r);
		$display("Rows: %0d, checks: %0d, errors: %0d", N_ROWS, check_count, error_count);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- proc_core.f
+incdir+include
hdl/isa_pkg.sv
hdl/datapath_pkg.sv
hdl/lifo_stack.sv
hdl/fetch_unit.sv
hdl/instr_dec.sv
hdl/exec_unit.sv
hdl/proc_core.sv
tb/proc_core_props.sv
tb/proc_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the proc_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
	--top-module proc_core_tb \
	-f proc_core.f \
	-o proc_core_sim

./obj_dir/proc_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
